/* hdl/fpu_pkg.sv */
package fpu_pkg;

    // ------------------------------------------------------------------
    // Core sizes
    // ------------------------------------------------------------------
    localparam int num_threads = 4;  // Lanes per warp.
    localparam int num_warps   = 4;
    localparam int nw_bits     = 2;  // Warp id width.
    localparam int nr_bits     = 5;  // Register index width.
    localparam int uuid_bits   = 16;
    localparam int fpuq_size   = 4;  // Requests in flight.
    localparam int fpuq_bits   = 2;  // Tag width.

    localparam logic [31:0] canonical_nan = 32'h7fc00000;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    // Accrued exception flags in the RISC-V fflags bit order.
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic [2:0] {
        fsgnj  = 3'd0,
        fsgnjn = 3'd1,
        fsgnjx = 3'd2,
        fmin   = 3'd3,
        fmax   = 3'd4,
        feq    = 3'd5,
        flt    = 3'd6,
        fle    = 3'd7
    } fpu_op_t;

    // Request metadata parked in the index buffer while operands compute.
    typedef struct packed {
        logic [uuid_bits-1:0]   uuid;
        logic [nw_bits-1:0]     wid;
        logic [num_threads-1:0] tmask;
        logic [31:0]            pc;
        logic [nr_bits-1:0]     rd;
        logic                   wb;
    } req_meta_t;

endpackage

/* hdl/fpu_index_buffer.sv */
`timescale 1ns/1ps

module fpu_index_buffer #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned size      = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      acquire,
    input  payload_t                  write_data,
    output logic [$clog2(size)-1:0]   write_addr,
    input  logic [$clog2(size)-1:0]   read_addr,
    output payload_t                  read_data,
    input  logic [$clog2(size)-1:0]   release_addr,
    input  logic                      release_slot,
    output logic                      full,
    output logic                      empty
);

    logic [size-1:0] valid_q;      // One occupancy bit per slot.
    payload_t        mem [size];

    // Lowest free slot wins, so scan from the top down.
    always_comb begin
        write_addr = '0;
        for (int i = size - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                write_addr = i[$clog2(size)-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (release_slot) begin
                valid_q[release_addr] <= 1'b0;
            end
            if (acquire) begin
                valid_q[write_addr] <= 1'b1;  // Never collides with a release.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            mem[write_addr] <= write_data;
        end
    end

    assign read_data = mem[read_addr];
    assign full      = &valid_q;
    assign empty     = ~|valid_q;

endmodule

/* hdl/fpu_ncomp_lane.sv */
`timescale 1ns/1ps

module fpu_ncomp_lane (
    input  fpu_pkg::fpu_op_t op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      result,
    output fpu_pkg::fflags_t flags
);
    import fpu_pkg::*;

    logic a_nan, b_nan, a_snan, b_snan;
    logic both_zero;
    logic lt_order;  // Total order where -0 sits below +0.
    logic lt_ieee;   // IEEE less-than where the two zeros are equal.
    logic eq_ieee;

    // ------------------------------------------------------------------
    // Operand classification
    // ------------------------------------------------------------------
    assign a_nan     = (a[30:23] == 8'hff) && (a[22:0] != '0);
    assign b_nan     = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign a_snan    = a_nan && !a[22];   // Quiet bit clear.
    assign b_snan    = b_nan && !b[22];
    assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);

    // A negative value is below a positive one; with equal signs the magnitude decides.
    assign lt_order = (a[31] != b[31]) ? a[31]
                    : (a[31] ? (b[30:0] < a[30:0]) : (a[30:0] < b[30:0]));
    assign lt_ieee  = lt_order && !both_zero;
    assign eq_ieee  = (a == b) || both_zero;

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------
    always_comb begin
        result = '0;
        flags  = '0;
        case (op)
            fsgnj:  result = {b[31], a[30:0]};
            fsgnjn: result = {~b[31], a[30:0]};
            fsgnjx: result = {a[31] ^ b[31], a[30:0]};
            fmin, fmax: begin
                if (a_nan && b_nan) begin
                    result = canonical_nan;
                end else if (a_nan) begin
                    result = b;
                end else if (b_nan) begin
                    result = a;
                end else if (op == fmin) begin
                    result = lt_order ? a : b;
                end else begin
                    result = lt_order ? b : a;
                end
                flags.nv = a_snan || b_snan;
            end
            feq: begin
                result   = {31'd0, eq_ieee && !a_nan && !b_nan};
                flags.nv = a_snan || b_snan;  // Quiet NaNs compare silently.
            end
            flt, fle: begin
                if (a_nan || b_nan) begin
                    flags.nv = 1'b1;
                end else if (op == flt) begin
                    result = {31'd0, lt_ieee};
                end else begin
                    result = {31'd0, lt_ieee || eq_ieee};
                end
            end
            default: result = '0;
        endcase
    end

endmodule

/* hdl/fpu_ncomp_pipe.sv */
`timescale 1ns/1ps

module fpu_ncomp_pipe #(
    parameter int tagw = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid_in,
    output logic                ready_in,
    input  logic [tagw-1:0]     tag_in,
    input  fpu_pkg::fpu_op_t    op,
    input  logic [31:0]         dataa [fpu_pkg::num_threads],
    input  logic [31:0]         datab [fpu_pkg::num_threads],
    output logic [31:0]         result [fpu_pkg::num_threads],
    output logic                has_fflags,
    output fpu_pkg::fflags_t    fflags [fpu_pkg::num_threads],
    output logic [tagw-1:0]     tag_out,
    output logic                valid_out,
    input  logic                ready_out
);
    import fpu_pkg::*;

    logic        s1_valid;
    fpu_op_t     s1_op;
    logic [31:0] s1_a [num_threads];
    logic [31:0] s1_b [num_threads];
    logic [tagw-1:0] s1_tag;

    logic [31:0] lane_result [num_threads];
    fflags_t     lane_flags [num_threads];
    logic        s1_has_fflags;

    // The whole pipe advances together, so its input readiness is the output's.
    assign ready_in = ready_out;

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        fpu_ncomp_lane lane_i (
            .op     (s1_op),
            .a      (s1_a[i]),
            .b      (s1_b[i]),
            .result (lane_result[i]),
            .flags  (lane_flags[i])
        );
    end

    assign s1_has_fflags = (s1_op == fmin) || (s1_op == fmax) || (s1_op == feq)
                        || (s1_op == flt) || (s1_op == fle);

    // ------------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            valid_out <= 1'b0;
        end else if (ready_out) begin
            s1_valid  <= valid_in;
            valid_out <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_out) begin
            s1_op      <= op;
            s1_a       <= dataa;
            s1_b       <= datab;
            s1_tag     <= tag_in;
            result     <= lane_result;
            fflags     <= lane_flags;
            has_fflags <= s1_has_fflags;
            tag_out    <= s1_tag;
        end
    end

endmodule

/* hdl/fpu_commit_stage.sv */
`timescale 1ns/1ps

module fpu_commit_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                valid_in,
    output logic                                ready_in,
    input  fpu_pkg::req_meta_t                  meta,
    input  logic [31:0]                         result [fpu_pkg::num_threads],
    input  logic                                has_fflags,
    input  fpu_pkg::fflags_t                    fflags [fpu_pkg::num_threads],
    output logic                                commit_valid,
    input  logic                                commit_ready,
    output logic [fpu_pkg::uuid_bits-1:0]       commit_uuid,
    output logic [fpu_pkg::nw_bits-1:0]         commit_wid,
    output logic [fpu_pkg::num_threads-1:0]     commit_tmask,
    output logic [31:0]                         commit_pc,
    output logic [fpu_pkg::nr_bits-1:0]         commit_rd,
    output logic                                commit_wb,
    output logic [31:0]                         commit_data [fpu_pkg::num_threads],
    output logic                                commit_eop,
    output logic                                csr_fflags_write,
    output logic [fpu_pkg::nw_bits-1:0]         csr_fflags_wid,
    output fpu_pkg::fflags_t                    csr_fflags
);
    import fpu_pkg::*;

    fflags_t   rsp_fflags;
    req_meta_t meta_q;
    logic      has_fflags_q;
    logic      stall;

    // Only active threads contribute to the accrued flags.
    always_comb begin
        rsp_fflags = '0;
        for (int i = 0; i < num_threads; i++) begin
            if (meta.tmask[i]) begin
                rsp_fflags = rsp_fflags | fflags[i];
            end
        end
    end

    assign stall    = commit_valid && !commit_ready;
    assign ready_in = !stall;

    // ------------------------------------------------------------------
    // Commit register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (!stall) begin
            commit_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            meta_q       <= meta;
            commit_data  <= result;
            has_fflags_q <= has_fflags;
            csr_fflags   <= rsp_fflags;
        end
    end

    assign commit_uuid  = meta_q.uuid;
    assign commit_wid   = meta_q.wid;
    assign commit_tmask = meta_q.tmask;
    assign commit_pc    = meta_q.pc;
    assign commit_rd    = meta_q.rd;
    assign commit_wb    = meta_q.wb;
    assign commit_eop   = 1'b1;  // Every result is a single packet.

    // Flags reach the CSR file only when the writeback actually takes the result.
    assign csr_fflags_write = commit_valid && commit_ready && has_fflags_q;
    assign csr_fflags_wid   = meta_q.wid;

endmodule

/* hdl/fpu_unit.sv */
`timescale 1ns/1ps

module fpu_unit (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                req_valid,
    output logic                                req_ready,
    input  logic [fpu_pkg::uuid_bits-1:0]       req_uuid,
    input  logic [fpu_pkg::nw_bits-1:0]         req_wid,
    input  logic [fpu_pkg::num_threads-1:0]     req_tmask,
    input  logic [31:0]                         req_pc,
    input  logic [fpu_pkg::nr_bits-1:0]         req_rd,
    input  logic                                req_wb,
    input  fpu_pkg::fpu_op_t                    req_op,
    input  logic [31:0]                         req_rs1_data [fpu_pkg::num_threads],
    input  logic [31:0]                         req_rs2_data [fpu_pkg::num_threads],

    output logic                                commit_valid,
    input  logic                                commit_ready,
    output logic [fpu_pkg::uuid_bits-1:0]       commit_uuid,
    output logic [fpu_pkg::nw_bits-1:0]         commit_wid,
    output logic [fpu_pkg::num_threads-1:0]     commit_tmask,
    output logic [31:0]                         commit_pc,
    output logic [fpu_pkg::nr_bits-1:0]         commit_rd,
    output logic                                commit_wb,
    output logic [31:0]                         commit_data [fpu_pkg::num_threads],
    output logic                                commit_eop,

    output logic                                csr_fflags_write,
    output logic [fpu_pkg::nw_bits-1:0]         csr_fflags_wid,
    output fpu_pkg::fflags_t                    csr_fflags,
    input  logic [fpu_pkg::num_warps-1:0]       csr_pending,
    output logic [fpu_pkg::num_warps-1:0]       pending
);
    import fpu_pkg::*;

    logic                 pipe_ready_in;
    logic                 pipe_valid_in;
    logic                 pipe_valid_out;
    logic                 pipe_ready_out;
    logic [fpuq_bits-1:0] tag_in;
    logic [fpuq_bits-1:0] tag_out;
    logic [31:0]          pipe_result [num_threads];
    fflags_t              pipe_fflags [num_threads];
    logic                 pipe_has_fflags;
    logic                 fpuq_full;
    logic                 fpuq_push;
    logic                 fpuq_pop;
    req_meta_t            req_meta;
    req_meta_t            rsp_meta;
    logic                 admit;

    // ------------------------------------------------------------------
    // Request admission
    // ------------------------------------------------------------------
    // A warp still waiting on a CSR update must not issue more FP work.
    assign admit     = !fpuq_full && !csr_pending[req_wid];
    assign req_ready = pipe_ready_in && admit;
    assign pipe_valid_in = req_valid && admit;

    assign fpuq_push = req_valid && req_ready;
    assign fpuq_pop  = pipe_valid_out && pipe_ready_out;

    assign req_meta = '{uuid: req_uuid, wid: req_wid, tmask: req_tmask,
                        pc: req_pc, rd: req_rd, wb: req_wb};

    fpu_index_buffer #(
        .payload_t (req_meta_t),
        .size      (fpuq_size)
    ) index_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .acquire      (fpuq_push),
        .write_data   (req_meta),
        .write_addr   (tag_in),
        .read_addr    (tag_out),
        .read_data    (rsp_meta),
        .release_addr (tag_out),
        .release_slot (fpuq_pop),
        .full         (fpuq_full),
        .empty        ()
    );

    fpu_ncomp_pipe #(
        .tagw (fpuq_bits)
    ) ncomp_pipe_i (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (pipe_valid_in),
        .ready_in   (pipe_ready_in),
        .tag_in     (tag_in),
        .op         (req_op),
        .dataa      (req_rs1_data),
        .datab      (req_rs2_data),
        .result     (pipe_result),
        .has_fflags (pipe_has_fflags),
        .fflags     (pipe_fflags),
        .tag_out    (tag_out),
        .valid_out  (pipe_valid_out),
        .ready_out  (pipe_ready_out)
    );

    fpu_commit_stage commit_stage_i (
        .clk              (clk),
        .reset            (reset),
        .valid_in         (pipe_valid_out),
        .ready_in         (pipe_ready_out),
        .meta             (rsp_meta),
        .result           (pipe_result),
        .has_fflags       (pipe_has_fflags),
        .fflags           (pipe_fflags),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit_uuid      (commit_uuid),
        .commit_wid       (commit_wid),
        .commit_tmask     (commit_tmask),
        .commit_pc        (commit_pc),
        .commit_rd        (commit_rd),
        .commit_wb        (commit_wb),
        .commit_data      (commit_data),
        .commit_eop       (commit_eop),
        .csr_fflags_write (csr_fflags_write),
        .csr_fflags_wid   (csr_fflags_wid),
        .csr_fflags       (csr_fflags)
    );

    // ------------------------------------------------------------------
    // Pending warps
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (commit_valid && commit_ready) begin
                pending[commit_wid] <= 1'b0;
            end
            if (fpuq_push) begin
                pending[req_wid] <= 1'b1;  // A new request beats a retiring one.
            end
        end
    end

endmodule

/* tb/fpu_unit_assertions.sv */
`timescale 1ns/1ps

module fpu_unit_assertions (
    input logic                            clk,
    input logic                            reset,
    input logic                            commit_valid,
    input logic                            commit_ready,
    input logic [fpu_pkg::uuid_bits-1:0]   commit_uuid,
    input logic [fpu_pkg::num_threads-1:0] commit_tmask,
    input logic [31:0]                     commit_pc,
    input logic [31:0]                     commit_data [fpu_pkg::num_threads],
    input logic                            csr_fflags_write,
    input logic [fpu_pkg::num_warps-1:0]   pending
);
    import fpu_pkg::*;

    logic [32*num_threads-1:0] data_flat;

    always_comb begin
        for (int i = 0; i < num_threads; i++) begin
            data_flat[32*i +: 32] = commit_data[i];
        end
    end

    // A stalled commit keeps its payload until writeback takes it.
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_uuid)
            && $stable(commit_tmask) && $stable(commit_pc) && $stable(data_flat))
        else $error("commit payload changed while the commit was stalled");

    // Each committed instruction posts its flags once, on its own fire.
    csr_on_fire: assert property (@(posedge clk) disable iff (reset)
        csr_fflags_write |-> commit_valid && commit_ready
            && !($past(csr_fflags_write) && $stable(commit_uuid)))
        else $error("csr_fflags_write raised without a fresh commit fire");

    reset_clear: assert property (@(posedge clk)
        reset |=> !commit_valid && (pending == '0))
        else $error("commit_valid or pending set after a reset cycle");

endmodule

/* tb/fpu_unit_tb.sv */
`timescale 1ns/1ps

module fpu_unit_tb;
    import fpu_pkg::*;

    typedef struct packed {
        fpu_op_t                   op;
        logic [nw_bits-1:0]        wid;
        logic [num_threads-1:0]    tmask;
        logic [num_warps-1:0]      pend;  // csr_pending pattern while offered.
        logic [32*num_threads-1:0] a;
        logic [32*num_threads-1:0] b;
    } entry_t;

    typedef struct packed {
        req_meta_t                 meta;
        logic [32*num_threads-1:0] data;
        fflags_t                   flags;
        logic                      has;
        logic                      timed;  // Fired with no back-pressure.
        logic [31:0]               cycle;
    } expect_t;

    localparam logic [31:0] pz   = 32'h00000000;
    localparam logic [31:0] mz   = 32'h80000000;
    localparam logic [31:0] p1   = 32'h3f800000;
    localparam logic [31:0] m1   = 32'hbf800000;
    localparam logic [31:0] p2   = 32'h40000000;
    localparam logic [31:0] m2   = 32'hc0000000;
    localparam logic [31:0] ph   = 32'h3f000000;
    localparam logic [31:0] pinf = 32'h7f800000;
    localparam logic [31:0] minf = 32'hff800000;
    localparam logic [31:0] qn   = 32'h7fc00000;
    localparam logic [31:0] mqn  = 32'hffc00000;
    localparam logic [31:0] sn   = 32'h7f800001;
    localparam logic [31:0] msn  = 32'hff800123;

    localparam int num_entries     = 16;
    localparam int watchdog_cycles = num_entries * 40;

    // ------------------------------------------------------------------
    // Stimulus table with lanes listed as {lane3, lane2, lane1, lane0}
    // ------------------------------------------------------------------
    localparam entry_t [0:num_entries-1] stim = '{
        '{fsgnj,  2'd0, 4'hf, 4'h0, {qn, pz, m2, p1}, {m1, minf, p1, mz}},
        '{fsgnjn, 2'd1, 4'hf, 4'h0, {sn, mz, p2, m1}, {pz, qn, m1, p1}},
        '{fsgnjx, 2'd2, 4'ha, 4'h4, {m2, ph, minf, m1}, {m1, m1, p1, m1}},
        '{fmin,   2'd3, 4'hf, 4'h0, {sn, qn, p1, pz}, {qn, p1, p2, mz}},
        '{fmax,   2'd0, 4'hf, 4'h0, {qn, sn, m1, mz}, {qn, p2, m2, pz}},
        '{feq,    2'd1, 4'hf, 4'h0, {sn, qn, pz, p1}, {p1, qn, mz, p1}},
        '{flt,    2'd2, 4'h3, 4'h1, {m2, qn, mz, p1}, {m1, p1, pz, p2}},
        '{fle,    2'd3, 4'hf, 4'h8, {sn, p2, mz, p1}, {p1, p1, pz, p1}},
        '{fmin,   2'd0, 4'h4, 4'h0, {p1, msn, pinf, m1}, {p2, p1, minf, m1}},
        '{feq,    2'd1, 4'h8, 4'h2, {qn, p1, ph, minf}, {p1, p1, m1, minf}},
        '{fsgnj,  2'd2, 4'hf, 4'h3, {p1, m1, pinf, mqn}, {m2, pz, mz, p1}},
        '{flt,    2'd3, 4'hf, 4'h0, {minf, pinf, m1, m2}, {pinf, minf, m2, m1}},
        '{fmax,   2'd0, 4'hf, 4'h0, {msn, mz, ph, m2}, {qn, mz, p1, pinf}},
        '{fle,    2'd1, 4'h1, 4'h0, {p1, p1, p1, qn}, {p1, p1, p1, p1}},
        '{fsgnjx, 2'd2, 4'hf, 4'h0, {mqn, sn, mz, m1}, {m1, m1, m1, m1}},
        '{feq,    2'd3, 4'h6, 4'h0, {m1, pz, sn, p2}, {m1, mz, p1, p2}}
    };

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   req_valid;
    logic                   req_ready;
    logic [uuid_bits-1:0]   req_uuid;
    logic [nw_bits-1:0]     req_wid;
    logic [num_threads-1:0] req_tmask;
    logic [31:0]            req_pc;
    logic [nr_bits-1:0]     req_rd;
    logic                   req_wb;
    fpu_op_t                req_op;
    logic [31:0]            req_rs1_data [num_threads];
    logic [31:0]            req_rs2_data [num_threads];
    logic                   commit_valid;
    logic                   commit_ready = 1'b1;
    logic [uuid_bits-1:0]   commit_uuid;
    logic [nw_bits-1:0]     commit_wid;
    logic [num_threads-1:0] commit_tmask;
    logic [31:0]            commit_pc;
    logic [nr_bits-1:0]     commit_rd;
    logic                   commit_wb;
    logic [31:0]            commit_data [num_threads];
    logic                   commit_eop;
    logic                   csr_fflags_write;
    logic [nw_bits-1:0]     csr_fflags_wid;
    fflags_t                csr_fflags;
    logic [num_warps-1:0]   csr_pending;
    logic [num_warps-1:0]   pending;

    expect_t              exp_q [$];
    logic [num_warps-1:0] pend_model = '0;
    logic [15:0]          uuid_ctr = 16'h0100;
    int                   cycle = 0;
    int                   ready_mode = 0;  // 0 always ready, 1 random, 2 held low.

    fpu_unit dut_i (.*);

    bind fpu_unit fpu_unit_assertions assertions_i (
        .clk              (clk),
        .reset            (reset),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit_uuid      (commit_uuid),
        .commit_tmask     (commit_tmask),
        .commit_pc        (commit_pc),
        .commit_data      (commit_data),
        .csr_fflags_write (csr_fflags_write),
        .pending          (pending)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    always @(posedge clk) begin
        case (ready_mode)
            0:       commit_ready <= 1'b1;
            1:       commit_ready <= ($urandom % 4) != 0;
            default: commit_ready <= 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // Maps a float to an unsigned key whose order is numeric with -0 below +0.
    function automatic logic [31:0] order_key(logic [31:0] x);
        return x[31] ? ~x : (x | 32'h80000000);
    endfunction

    function automatic void lane_model(input fpu_op_t op, input logic [31:0] a,
                                       input logic [31:0] b, output logic [31:0] res,
                                       output fflags_t fl);
        logic a_nan;
        logic b_nan;
        logic snan;
        logic zeros;
        logic lt;
        logic eq;
        a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
        zeros = ((a | b) & 32'h7fffffff) == 32'd0;
        lt    = order_key(a) < order_key(b);
        eq    = (a == b) || zeros;
        res   = '0;
        fl    = '0;
        case (op)
            fsgnj:  res = {b[31], a[30:0]};
            fsgnjn: res = {!b[31], a[30:0]};
            fsgnjx: res = {a[31] ^ b[31], a[30:0]};
            fmin, fmax: begin
                if (a_nan && b_nan) begin
                    res = canonical_nan;
                end else if (a_nan || b_nan) begin
                    res = a_nan ? b : a;
                end else if (op == fmin) begin
                    res = lt ? a : b;
                end else begin
                    res = lt ? b : a;
                end
                fl.nv = snan;
            end
            feq: begin
                res   = {31'd0, eq && !a_nan && !b_nan};
                fl.nv = snan;
            end
            flt: begin
                res   = {31'd0, lt && !zeros && !a_nan && !b_nan};
                fl.nv = a_nan || b_nan;
            end
            default: begin
                res   = {31'd0, (lt || eq) && !a_nan && !b_nan};
                fl.nv = a_nan || b_nan;
            end
        endcase
    endfunction

    function automatic req_meta_t request_meta(entry_t e, logic [15:0] uuid);
        req_meta_t m;
        m.uuid  = uuid;
        m.wid   = e.wid;
        m.tmask = e.tmask;
        m.pc    = 32'h8000_0000 + {14'd0, uuid, 2'b00};
        m.rd    = uuid[4:0];
        m.wb    = ~uuid[0];
        return m;
    endfunction

    function automatic expect_t expected_result(entry_t e, logic [15:0] uuid,
                                                int at_cycle, logic timed);
        expect_t     ex;
        logic [31:0] lane_res;
        fflags_t     lane_fl;
        ex.meta  = request_meta(e, uuid);
        ex.flags = '0;
        ex.has   = e.op inside {fmin, fmax, feq, flt, fle};
        ex.timed = timed;
        ex.cycle = 32'(at_cycle);
        for (int i = 0; i < num_threads; i++) begin
            lane_model(e.op, e.a[32*i +: 32], e.b[32*i +: 32], lane_res, lane_fl);
            ex.data[32*i +: 32] = lane_res;
            if (e.tmask[i]) begin
                ex.flags = ex.flags | lane_fl;
            end
        end
        return ex;
    endfunction

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic require(logic cond, string what);
        assert (cond) else begin
            $display("Error at time %0t: %s", $time, what);
            $display("Simulation FAILED");
            $fatal(1, "%s", what);
        end
    endtask

    always @(posedge clk) begin
        expect_t ex;
        if (!reset) begin
            compare_value("pending", 32'(pend_model), 32'(pending));
            if (commit_valid && commit_ready) begin
                require(exp_q.size() != 0, "a commit fired with no request outstanding");
                ex = exp_q.pop_front();
                compare_value("commit_uuid", 32'(ex.meta.uuid), 32'(commit_uuid));
                compare_value("commit_wid", 32'(ex.meta.wid), 32'(commit_wid));
                compare_value("commit_tmask", 32'(ex.meta.tmask), 32'(commit_tmask));
                compare_value("commit_pc", ex.meta.pc, commit_pc);
                compare_value("commit_rd", 32'(ex.meta.rd), 32'(commit_rd));
                compare_value("commit_wb", 32'(ex.meta.wb), 32'(commit_wb));
                compare_value("commit_eop", 32'd1, 32'(commit_eop));
                for (int i = 0; i < num_threads; i++) begin
                    compare_value($sformatf("commit_data[%0d]", i), ex.data[32*i +: 32],
                                  commit_data[i]);
                end
                compare_value("csr_fflags_write", 32'(ex.has), 32'(csr_fflags_write));
                if (ex.has) begin
                    compare_value("csr_fflags", 32'(ex.flags), 32'(csr_fflags));
                    compare_value("csr_fflags_wid", 32'(ex.meta.wid), 32'(csr_fflags_wid));
                end
                if (ex.timed) begin
                    compare_value("latency", 32'd3, 32'(cycle) - ex.cycle);
                end
                pend_model[ex.meta.wid] = 1'b0;
            end else begin
                require(!csr_fflags_write, "csr_fflags_write was high without a commit fire");
            end
            if (req_valid && req_ready) begin
                pend_model[req_wid] = 1'b1;  // Set wins over a same-cycle clear.
            end
        end
    end

    // ------------------------------------------------------------------
    // Driver
    // ------------------------------------------------------------------
    task automatic apply_entry(int idx);
        req_meta_t m;
        m = request_meta(stim[idx], uuid_ctr);
        req_valid <= 1'b1;
        req_uuid  <= m.uuid;
        req_wid   <= m.wid;
        req_tmask <= m.tmask;
        req_pc    <= m.pc;
        req_rd    <= m.rd;
        req_wb    <= m.wb;
        req_op    <= stim[idx].op;
        for (int i = 0; i < num_threads; i++) begin
            req_rs1_data[i] <= stim[idx].a[32*i +: 32];
            req_rs2_data[i] <= stim[idx].b[32*i +: 32];
        end
    endtask

    task automatic record_fire(int idx);
        exp_q.push_back(expected_result(stim[idx], uuid_ctr, cycle, ready_mode == 0));
        uuid_ctr++;
    endtask

    // Called at a rising edge; returns at the edge where the entry fires.
    task automatic offer_entry(int idx);
        apply_entry(idx);
        csr_pending <= stim[idx].pend;
        if (stim[idx].pend[stim[idx].wid]) begin
            repeat (3) begin
                @(posedge clk);
                require(!req_ready, "req_ready was high for a warp with csr_pending set");
            end
            csr_pending <= '0;
        end
        @(posedge clk);
        while (!(req_valid && req_ready)) @(posedge clk);
        record_fire(idx);
    endtask

    task automatic drain_scoreboard();
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
    endtask

    // Offers requests back to back while writeback refuses every commit.
    task automatic fill_without_commit();
        int idx;
        int taken;
        idx   = 0;
        taken = 0;
        csr_pending <= '0;
        apply_entry(idx);
        repeat (12) begin
            @(posedge clk);
            if (req_valid && req_ready) begin
                record_fire(idx);
                taken++;
                idx++;
                apply_entry(idx);
            end
        end
        require(taken <= fpuq_size, "more requests accepted than the unit can hold");
        require(!req_ready, "req_ready stayed high while commit_ready was held low");
        req_valid <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hc60c57be));
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_uuid    = '0;
        req_wid     = '0;
        req_tmask   = '0;
        req_pc      = '0;
        req_rd      = '0;
        req_wb      = 1'b0;
        req_op      = fsgnj;
        csr_pending = '0;
        for (int i = 0; i < num_threads; i++) begin
            req_rs1_data[i] = '0;
            req_rs2_data[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < num_entries; i++) offer_entry(i);  // No back-pressure.
        req_valid <= 1'b0;
        drain_scoreboard();

        ready_mode = 1;
        @(posedge clk);
        for (int i = 0; i < num_entries; i++) offer_entry(i);
        req_valid <= 1'b0;
        drain_scoreboard();

        ready_mode = 2;
        repeat (2) @(posedge clk);
        fill_without_commit();
        ready_mode = 0;
        drain_scoreboard();

        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* fpu_unit.f */
hdl/fpu_pkg.sv
hdl/fpu_index_buffer.sv
hdl/fpu_ncomp_lane.sv
hdl/fpu_ncomp_pipe.sv
hdl/fpu_commit_stage.sv
hdl/fpu_unit.sv
tb/fpu_unit_assertions.sv
tb/fpu_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the fpu_unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module fpu_unit_tb \
    -f fpu_unit.f -o fpu_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/fpu_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
    exit 1
fi
exit 0
